//--- crc_consts.svh
// Width constants, reset defaults and register word offsets for the CRC engine
`ifndef CRC_CONSTS_SVH
`define CRC_CONSTS_SVH

// Data path widths
`define CRC_DATA_W 32
`define CRC_W 32
`define CRC_LANES 4
`define CRC_AXI_AW 5

// Reset defaults, CRC-32 Ethernet
`define CRC_INIT_POLY 32'h04C1_1DB7
`define CRC_INIT_SEED 32'hFFFF_FFFF
`define CRC_INIT_XOROUT 32'hFFFF_FFFF
`define CRC_INIT_REFIN 1'b1
`define CRC_INIT_REFOUT 1'b1

// Register word offsets, byte address bits [4:2]
`define CRC_REG_CTRL 3'd0
`define CRC_REG_POLY 3'd1
`define CRC_REG_SEED 3'd2
`define CRC_REG_XOROUT 3'd3
`define CRC_REG_RESULT 3'd4
`define CRC_REG_PKT_COUNT 3'd5

`endif

//--- crc_pkg.sv
// Beat, configuration and result structs
// Register offset and write FSM enums
`include "crc_consts.svh"

package crc_pkg;

    // One data beat, byte 0 in the low bits goes first
    typedef struct packed {
        logic                   valid;
        logic                   sop;
        logic                   last;
        // 1 to 4, only looked at on the last beat
        logic [2:0]             byte_cnt;
        logic [`CRC_DATA_W-1:0] data;
    } crc_beat_t;

    // Programmed algorithm
    typedef struct packed {
        logic [`CRC_W-1:0] poly;
        logic [`CRC_W-1:0] seed;
        logic [`CRC_W-1:0] xor_out;
        logic              refin;
        logic              refout;
    } crc_cfg_t;

    // Finished CRC, valid for one cycle
    typedef struct packed {
        logic              valid;
        logic [`CRC_W-1:0] crc;
    } crc_result_t;

    // Word offsets of the register map
    typedef enum logic [`CRC_AXI_AW-3:0] {
        REG_CTRL      = `CRC_REG_CTRL,
        REG_POLY      = `CRC_REG_POLY,
        REG_SEED      = `CRC_REG_SEED,
        REG_XOROUT    = `CRC_REG_XOROUT,
        REG_RESULT    = `CRC_REG_RESULT,
        REG_PKT_COUNT = `CRC_REG_PKT_COUNT
    } crc_reg_e;

    // AXI write channel sequencing
    typedef enum logic [1:0] {
        WR_IDLE,
        WR_DATA,
        WR_RESP
    } axil_wr_state_e;

endpackage

//--- crc_byte_stage.sv
// One byte of the CRC cascade
// Byte XOR into the top of the state, then eight polynomial shift steps
`timescale 1ns/1ps
`include "crc_consts.svh"

module crc_byte_stage (
    input  logic [`CRC_W-1:0] state_in,
    input  logic [`CRC_W-1:0] poly,
    input  logic [7:0]        data_byte,
    output logic [`CRC_W-1:0] state_out
);

    // ----------------------------------------------------------
    // XOR-shift, MSB first, non-reflected polynomial
    // ----------------------------------------------------------
    always_comb begin
        // Byte lands on the top eight state bits
        state_out = state_in ^ {data_byte, {(`CRC_W-8){1'b0}}};
        // Unrolled, eight steps per byte
        for (int i = 0; i < 8; i++) begin
            if (state_out[`CRC_W-1]) begin
                state_out = {state_out[`CRC_W-2:0], 1'b0} ^ poly;
            end else begin
                state_out = {state_out[`CRC_W-2:0], 1'b0};
            end
        end
    end

endmodule

//--- crc_engine.sv
// Input reflection, four byte cascade and byte count select
// State and result registers with output reflection and XOR mask
`timescale 1ns/1ps
`include "crc_consts.svh"

module crc_engine
    import crc_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  crc_cfg_t    cfg,
    input  crc_beat_t   in_beat,
    output crc_result_t result
);

    // Bit reverse inside a byte
    function automatic logic [7:0] rev8(input logic [7:0] b);
        logic [7:0] r;
        for (int i = 0; i < 8; i++) begin
            r[i] = b[7-i];
        end
        return r;
    endfunction

    // Bit reverse of the whole CRC
    function automatic logic [`CRC_W-1:0] rev_crc(input logic [`CRC_W-1:0] v);
        logic [`CRC_W-1:0] r;
        for (int i = 0; i < `CRC_W; i++) begin
            r[i] = v[`CRC_W-1-i];
        end
        return r;
    endfunction

    logic [7:0]        lane_byte [`CRC_LANES];
    // chain[n] holds the CRC after n bytes of the beat
    logic [`CRC_W-1:0] chain [`CRC_LANES+1];
    logic [`CRC_W-1:0] next_state;
    logic [`CRC_W-1:0] state_q;
    logic [`CRC_W-1:0] final_crc;
    logic              last_q;

    // ----------------------------------------------------------
    // Cascade
    // ----------------------------------------------------------
    // Seed enters directly on start of packet
    assign chain[0] = in_beat.sop ? cfg.seed : state_q;

    for (genvar g = 0; g < `CRC_LANES; g++) begin : g_lane
        // LSB-first protocols need each byte flipped
        assign lane_byte[g] = cfg.refin ? rev8(in_beat.data[g*8 +: 8])
                                        : in_beat.data[g*8 +: 8];

        crc_byte_stage u_stage (
            .state_in  (chain[g]),
            .poly      (cfg.poly),
            .data_byte (lane_byte[g]),
            .state_out (chain[g+1])
        );
    end

    // Tap point by byte count on the last beat
    always_comb begin
        next_state = chain[`CRC_LANES];
        if (in_beat.last) begin
            for (int i = 1; i <= `CRC_LANES; i++) begin
                if (in_beat.byte_cnt == 3'(i)) begin
                    next_state = chain[i];
                end
            end
        end
    end

    // ----------------------------------------------------------
    // State and result registers
    // ----------------------------------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q <= '0;
            last_q  <= 1'b0;
        end else begin
            last_q <= in_beat.valid && in_beat.last;
            // Idle cycles hold the state
            if (in_beat.valid) begin
                state_q <= next_state;
            end
        end
    end

    // Output reflection comes before the XOR mask
    assign final_crc = (cfg.refout ? rev_crc(state_q) : state_q) ^ cfg.xor_out;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            result.valid <= 1'b0;
        end else begin
            result.valid <= last_q;
            if (last_q) begin
                result.crc <= final_crc;
            end
        end
    end

    // ----------------------------------------------------------
    // Checks
    // ----------------------------------------------------------
    // Final beat must name one to four bytes
    a_byte_cnt: assert property (@(posedge clk) disable iff (!rst_n)
        in_beat.valid && in_beat.last |-> in_beat.byte_cnt inside {[3'd1:3'd4]});

    // Two results in a row only when the second packet was a single beat
    a_result_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        result.valid && $past(result.valid) |-> $past(in_beat.sop, 2));

endmodule

//--- crc_axil_regs.sv
// AXI4-Lite slave with the CRC configuration registers,
// captured result and finished packet count
`timescale 1ns/1ps
`include "crc_consts.svh"

module crc_axil_regs
    import crc_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst_n,
    // Write address, data and response
    input  logic [`CRC_AXI_AW-1:0] awaddr,
    input  logic                   awvalid,
    output logic                   awready,
    input  logic [31:0]            wdata,
    input  logic [3:0]             wstrb,
    input  logic                   wvalid,
    output logic                   wready,
    output logic [1:0]             bresp,
    output logic                   bvalid,
    input  logic                   bready,
    // Read address and data
    input  logic [`CRC_AXI_AW-1:0] araddr,
    input  logic                   arvalid,
    output logic                   arready,
    output logic [31:0]            rdata,
    output logic [1:0]             rresp,
    output logic                   rvalid,
    input  logic                   rready,
    // Engine side
    input  crc_result_t            result,
    output crc_cfg_t               cfg
);

    // Byte-lane merge under wstrb
    function automatic logic [31:0] merge_strb(input logic [31:0] old_v,
                                               input logic [31:0] new_v,
                                               input logic [3:0]  strb);
        logic [31:0] m;
        for (int i = 0; i < 4; i++) begin
            m[i*8 +: 8] = strb[i] ? new_v[i*8 +: 8] : old_v[i*8 +: 8];
        end
        return m;
    endfunction

    axil_wr_state_e wr_state;
    crc_reg_e       wr_off;
    crc_reg_e       rd_off;
    logic [31:0]    rd_mux;
    logic [31:0]    result_q;
    logic [31:0]    pkt_count;

    // Always OKAY, unmapped accesses included
    assign bresp = 2'b00;
    assign rresp = 2'b00;

    // ----------------------------------------------------------
    // Write channel FSM
    // ----------------------------------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_state <= WR_IDLE;
            awready  <= 1'b0;
            wready   <= 1'b0;
            bvalid   <= 1'b0;
            cfg.poly    <= `CRC_INIT_POLY;
            cfg.seed    <= `CRC_INIT_SEED;
            cfg.xor_out <= `CRC_INIT_XOROUT;
            cfg.refin   <= `CRC_INIT_REFIN;
            cfg.refout  <= `CRC_INIT_REFOUT;
        end else begin
            case (wr_state)
                WR_IDLE: begin
                    awready <= 1'b1;
                    if (awvalid && awready) begin
                        wr_off   <= crc_reg_e'(awaddr[`CRC_AXI_AW-1:2]);
                        awready  <= 1'b0;
                        wready   <= 1'b1;
                        wr_state <= WR_DATA;
                    end
                end
                WR_DATA: begin
                    if (wvalid && wready) begin
                        wready   <= 1'b0;
                        bvalid   <= 1'b1;
                        wr_state <= WR_RESP;
                        // RESULT, PKT_COUNT and holes ignore writes
                        case (wr_off)
                            REG_CTRL: begin
                                if (wstrb[0]) begin
                                    cfg.refin  <= wdata[0];
                                    cfg.refout <= wdata[1];
                                end
                            end
                            REG_POLY:   cfg.poly    <= merge_strb(cfg.poly, wdata, wstrb);
                            REG_SEED:   cfg.seed    <= merge_strb(cfg.seed, wdata, wstrb);
                            REG_XOROUT: cfg.xor_out <= merge_strb(cfg.xor_out, wdata, wstrb);
                            default: ;
                        endcase
                    end
                end
                WR_RESP: begin
                    // Response held until the master takes it
                    if (bready) begin
                        bvalid   <= 1'b0;
                        wr_state <= WR_IDLE;
                    end
                end
                default: wr_state <= WR_IDLE;
            endcase
        end
    end

    // ----------------------------------------------------------
    // Read channel, one-deep response
    // ----------------------------------------------------------
    assign rd_off = crc_reg_e'(araddr[`CRC_AXI_AW-1:2]);

    always_comb begin
        case (rd_off)
            REG_CTRL:      rd_mux = {30'd0, cfg.refout, cfg.refin};
            REG_POLY:      rd_mux = cfg.poly;
            REG_SEED:      rd_mux = cfg.seed;
            REG_XOROUT:    rd_mux = cfg.xor_out;
            REG_RESULT:    rd_mux = result_q;
            REG_PKT_COUNT: rd_mux = pkt_count;
            default:       rd_mux = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            arready <= 1'b0;
            rvalid  <= 1'b0;
        end else if (arvalid && arready) begin
            arready <= 1'b0;
            rvalid  <= 1'b1;
            rdata   <= rd_mux;
        end else if (rvalid && rready) begin
            rvalid <= 1'b0;
        end else if (!rvalid) begin
            arready <= 1'b1;
        end
    end

    // Result capture and packet counter
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            result_q  <= '0;
            pkt_count <= '0;
        end else if (result.valid) begin
            result_q  <= result.crc;
            pkt_count <= pkt_count + 32'd1;
        end
    end

    // ----------------------------------------------------------
    // Checks
    // ----------------------------------------------------------
    a_bvalid_hold: assert property (@(posedge clk) disable iff (!rst_n)
        bvalid && !bready |=> bvalid);

    a_rdata_stable: assert property (@(posedge clk) disable iff (!rst_n)
        rvalid && !rready |=> rvalid && $stable(rdata));

endmodule

//--- crc_top.sv
// CRC top level: AXI4-Lite register block and CRC engine
`timescale 1ns/1ps
`include "crc_consts.svh"

module crc_top
    import crc_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst_n,
    // AXI4-Lite write
    input  logic [`CRC_AXI_AW-1:0] awaddr,
    input  logic                   awvalid,
    output logic                   awready,
    input  logic [31:0]            wdata,
    input  logic [3:0]             wstrb,
    input  logic                   wvalid,
    output logic                   wready,
    output logic [1:0]             bresp,
    output logic                   bvalid,
    input  logic                   bready,
    // AXI4-Lite read
    input  logic [`CRC_AXI_AW-1:0] araddr,
    input  logic                   arvalid,
    output logic                   arready,
    output logic [31:0]            rdata,
    output logic [1:0]             rresp,
    output logic                   rvalid,
    input  logic                   rready,
    // Packet data and finished CRC
    input  crc_beat_t              in_beat,
    output crc_result_t            result
);

    // Live configuration to the engine
    crc_cfg_t cfg;

    crc_axil_regs u_regs (
        .clk     (clk),
        .rst_n   (rst_n),
        .awaddr  (awaddr),
        .awvalid (awvalid),
        .awready (awready),
        .wdata   (wdata),
        .wstrb   (wstrb),
        .wvalid  (wvalid),
        .wready  (wready),
        .bresp   (bresp),
        .bvalid  (bvalid),
        .bready  (bready),
        .araddr  (araddr),
        .arvalid (arvalid),
        .arready (arready),
        .rdata   (rdata),
        .rresp   (rresp),
        .rvalid  (rvalid),
        .rready  (rready),
        .result  (result),
        .cfg     (cfg)
    );

    crc_engine u_engine (
        .clk     (clk),
        .rst_n   (rst_n),
        .cfg     (cfg),
        .in_beat (in_beat),
        .result  (result)
    );

endmodule

//--- tb_crc_top.sv
// Testbench for the CRC top level with AXI tasks and beat driver
// Reference CRC model, result monitor and reporting
`timescale 1ns/1ps
`include "crc_consts.svh"

module tb_crc_top
    import crc_pkg::*;
();

    // Cycles allowed for any single handshake wait
    localparam int TMO = 200;
    // Cycles past the due cycle before a missing result is reported
    localparam int MON_TMO = 20;

    logic                   clk;
    logic                   rst_n;
    logic [`CRC_AXI_AW-1:0] awaddr;
    logic                   awvalid;
    logic                   awready;
    logic [31:0]            wdata;
    logic [3:0]             wstrb;
    logic                   wvalid;
    logic                   wready;
    logic [1:0]             bresp;
    logic                   bvalid;
    logic                   bready;
    logic [`CRC_AXI_AW-1:0] araddr;
    logic                   arvalid;
    logic                   arready;
    logic [31:0]            rdata;
    logic [1:0]             rresp;
    logic                   rvalid;
    logic                   rready;
    crc_beat_t              in_beat;
    crc_result_t            result;

    int          pass_cnt = 0;
    int          fail_cnt = 0;
    int          test_fails = 0;
    int          cyc = 0;
    int          pkt_sent = 0;
    logic [31:0] last_crc;
    // Configuration as the testbench programmed it
    crc_cfg_t    cur_cfg;
    // Expected CRCs in packet order and the cycle each is due
    logic [31:0] exp_crc [$];
    int          exp_due [$];

    crc_top dut0 (
        .clk     (clk),
        .rst_n   (rst_n),
        .awaddr  (awaddr),
        .awvalid (awvalid),
        .awready (awready),
        .wdata   (wdata),
        .wstrb   (wstrb),
        .wvalid  (wvalid),
        .wready  (wready),
        .bresp   (bresp),
        .bvalid  (bvalid),
        .bready  (bready),
        .araddr  (araddr),
        .arvalid (arvalid),
        .arready (arready),
        .rdata   (rdata),
        .rresp   (rresp),
        .rvalid  (rvalid),
        .rready  (rready),
        .in_beat (in_beat),
        .result  (result)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Edge count that still reads the old value right after an edge
    always @(posedge clk) begin
        cyc <= cyc + 1;
    end

    // ----------------------------------------------------------
    // Reference model and compare tasks
    // ----------------------------------------------------------
    // Bit-serial CRC shifted MSB first against the non-reflected polynomial
    function automatic logic [31:0] crc_ref(input logic [7:0] data [$], input crc_cfg_t c);
        logic [31:0] crc;
        logic [31:0] out;
        logic        fb;
        crc = c.seed;
        foreach (data[i]) begin
            for (int k = 0; k < 8; k++) begin
                // Reflected input sends bit 0 of each byte first
                fb  = crc[31] ^ (c.refin ? data[i][k] : data[i][7-k]);
                crc = {crc[30:0], 1'b0} ^ (fb ? c.poly : 32'h0);
            end
        end
        for (int k = 0; k < 32; k++) begin
            out[k] = c.refout ? crc[31-k] : crc[k];
        end
        return out ^ c.xor_out;
    endfunction

    task automatic note_error(input string what);
        fail_cnt++;
        $display("ERROR at %0t ns: %s", $time, what);
    endtask

    task automatic check_result(input crc_result_t exp, input crc_result_t act);
        if (act === exp) begin
            pass_cnt++;
        end else begin
            fail_cnt++;
            $display("FAILED at %0t ns: result expected valid=%0b crc=%08h, %s",
                     $time, exp.valid, exp.crc,
                     $sformatf("actual valid=%0b crc=%08h", act.valid, act.crc));
        end
    endtask

    task automatic check_reg(input crc_reg_e off, input logic [31:0] exp, input logic [31:0] act);
        if (act === exp) begin
            pass_cnt++;
        end else begin
            fail_cnt++;
            $display("FAILED at %0t ns: %s expected %08h, actual %08h",
                     $time, off.name(), exp, act);
        end
    endtask

    task automatic end_test(input string name);
        if (fail_cnt == test_fails) begin
            $display("test %s: pass", name);
        end else begin
            $display("test %s: fail, %0d errors", name, fail_cnt - test_fails);
        end
        test_fails = fail_cnt;
    endtask

    // ----------------------------------------------------------
    // AXI4-Lite master
    // ----------------------------------------------------------
    task automatic axi_write(input crc_reg_e off, input logic [31:0] data);
        int n;
        @(posedge clk);
        awaddr  <= {off, 2'b00};
        awvalid <= 1'b1;
        wdata   <= data;
        wstrb   <= 4'hF;
        wvalid  <= 1'b1;
        // Address first, then data, then response
        n = 0;
        do begin
            @(posedge clk);
            n++;
        end while (!awready && n < TMO);
        awvalid <= 1'b0;
        if (!awready) note_error("write address was never accepted");
        n = 0;
        do begin
            @(posedge clk);
            n++;
        end while (!wready && n < TMO);
        wvalid <= 1'b0;
        if (!wready) note_error("write data was never accepted");
        n = 0;
        do begin
            @(posedge clk);
            n++;
        end while (!bvalid && n < TMO);
        if (!bvalid) note_error("write response never arrived");
        if (bvalid && bresp !== 2'b00) note_error("write response was not OKAY");
    endtask

    task automatic axi_read(input crc_reg_e off, input int stall, output logic [31:0] data);
        int n;
        @(posedge clk);
        araddr  <= {off, 2'b00};
        arvalid <= 1'b1;
        rready  <= (stall == 0);
        n = 0;
        do begin
            @(posedge clk);
            n++;
        end while (!arready && n < TMO);
        arvalid <= 1'b0;
        if (!arready) note_error("read address was never accepted");
        n = 0;
        do begin
            @(posedge clk);
            n++;
        end while (!rvalid && n < TMO);
        if (!rvalid) note_error("read data never arrived");
        if (rvalid && rresp !== 2'b00) note_error("read response was not OKAY");
        // Response held back with rready low
        if (stall > 0) begin
            repeat (stall) @(posedge clk);
            rready <= 1'b1;
            @(posedge clk);
        end
        data = rdata;
    endtask

    task automatic read_check(input crc_reg_e off, input int stall, input logic [31:0] exp);
        logic [31:0] got;
        axi_read(off, stall, got);
        check_reg(off, exp, got);
    endtask

    task automatic program_cfg(input crc_cfg_t c);
        axi_write(REG_CTRL, {30'd0, c.refout, c.refin});
        axi_write(REG_POLY, c.poly);
        axi_write(REG_SEED, c.seed);
        axi_write(REG_XOROUT, c.xor_out);
        cur_cfg = c;
    endtask

    // ----------------------------------------------------------
    // Beat driver
    // ----------------------------------------------------------
    task automatic send_packet(input logic [7:0] data [$], input int max_gap);
        crc_beat_t   beat;
        logic [31:0] crc;
        int          nbeats;
        int          idx;
        nbeats = (data.size() + 3) / 4;
        for (int b = 0; b < nbeats; b++) begin
            // Idle cycles only inside a packet
            if (b > 0 && max_gap > 0) begin
                repeat ($urandom_range(max_gap, 0)) begin
                    @(posedge clk);
                    in_beat <= '0;
                end
            end
            beat.valid    = 1'b1;
            beat.sop      = (b == 0);
            beat.last     = (b == nbeats - 1);
            beat.byte_cnt = beat.last ? 3'(data.size() - 4 * b) : 3'd4;
            for (int l = 0; l < 4; l++) begin
                idx = 4 * b + l;
                // Lanes past the end carry junk
                beat.data[l*8 +: 8] = (idx < data.size()) ? data[idx] : 8'($urandom);
            end
            @(posedge clk);
            in_beat <= beat;
        end
        // Monitor sees this result three edges after the last beat is driven
        crc = crc_ref(data, cur_cfg);
        exp_crc.push_back(crc);
        exp_due.push_back(cyc + 3);
        last_crc = crc;
        pkt_sent++;
    endtask

    // Idle the bus and wait for every outstanding result
    task automatic drain_results();
        int n;
        @(posedge clk);
        in_beat <= '0;
        n = 0;
        while (exp_crc.size() > 0 && n < TMO) begin
            @(posedge clk);
            n++;
        end
        if (exp_crc.size() > 0) note_error("results still outstanding after the packets");
    endtask

    // ----------------------------------------------------------
    // Result monitor
    // ----------------------------------------------------------
    always @(posedge clk) begin : monitor
        crc_result_t exp_r;
        if (rst_n) begin
            if (result.valid) begin
                if (exp_crc.size() == 0) begin
                    note_error("result.valid with no packet outstanding");
                end else begin
                    exp_r.valid = 1'b1;
                    exp_r.crc   = exp_crc.pop_front();
                    check_result(exp_r, result);
                    if (cyc != exp_due[0]) begin
                        note_error($sformatf("result at cycle %0d, due at cycle %0d",
                                             cyc, exp_due[0]));
                    end
                    void'(exp_due.pop_front());
                end
            end else if (exp_due.size() > 0 && cyc > exp_due[0] + MON_TMO) begin
                note_error("timed out waiting for result.valid");
                void'(exp_crc.pop_front());
                void'(exp_due.pop_front());
            end
        end
    end

    // ----------------------------------------------------------
    // Test sequence
    // ----------------------------------------------------------
    initial begin
        logic [7:0]  check_str [$];
        logic [7:0]  pkt [$];
        crc_cfg_t    cfg_r;
        crc_result_t known_r;
        crc_result_t ref_r;
        int          len;
        void'($urandom(61499));
        rst_n   = 1'b0;
        awaddr  = '0;
        awvalid = 1'b0;
        wdata   = '0;
        wstrb   = '0;
        wvalid  = 1'b0;
        bready  = 1'b1;
        araddr  = '0;
        arvalid = 1'b0;
        rready  = 1'b1;
        in_beat = '0;
        cur_cfg.poly    = `CRC_INIT_POLY;
        cur_cfg.seed    = `CRC_INIT_SEED;
        cur_cfg.xor_out = `CRC_INIT_XOROUT;
        cur_cfg.refin   = `CRC_INIT_REFIN;
        cur_cfg.refout  = `CRC_INIT_REFOUT;
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;

        // Defaults after reset
        read_check(REG_CTRL, 0, {30'd0, `CRC_INIT_REFOUT, `CRC_INIT_REFIN});
        read_check(REG_POLY, 0, `CRC_INIT_POLY);
        read_check(REG_SEED, 0, `CRC_INIT_SEED);
        read_check(REG_XOROUT, 0, `CRC_INIT_XOROUT);
        read_check(REG_RESULT, 0, 32'h0);
        read_check(REG_PKT_COUNT, 0, 32'h0);
        end_test("1 reset defaults");

        // CRC-32 Ethernet check value over "123456789"
        for (int i = 0; i < 9; i++) begin
            check_str.push_back(8'h31 + 8'(i));
        end
        known_r = {1'b1, 32'hCBF4_3926};
        ref_r   = {1'b1, crc_ref(check_str, cur_cfg)};
        check_result(known_r, ref_r);
        send_packet(check_str, 0);
        drain_results();
        end_test("2 crc32 check value");

        // BZIP2 without reflection
        cfg_r        = cur_cfg;
        cfg_r.refin  = 1'b0;
        cfg_r.refout = 1'b0;
        program_cfg(cfg_r);
        read_check(REG_CTRL, 0, 32'h0);
        known_r = {1'b1, 32'hFC89_1918};
        ref_r   = {1'b1, crc_ref(check_str, cur_cfg)};
        check_result(known_r, ref_r);
        send_packet(check_str, 0);
        drain_results();
        end_test("3 bzip2 check value");

        // Random algorithms over every final byte count
        for (int c = 0; c < 6; c++) begin
            cfg_r.poly    = $urandom;
            cfg_r.seed    = $urandom;
            cfg_r.xor_out = $urandom;
            cfg_r.refin   = 1'($urandom_range(1, 0));
            cfg_r.refout  = 1'($urandom_range(1, 0));
            program_cfg(cfg_r);
            for (int p = 0; p < 8; p++) begin
                len = 4 * $urandom_range(9, 0) + (p % 4) + 1;
                pkt.delete();
                repeat (len) pkt.push_back(8'($urandom));
                send_packet(pkt, 0);
            end
            drain_results();
        end
        end_test("4 random algorithms");

        // Back to back with idle cycles inside packets
        for (int p = 0; p < 12; p++) begin
            len = 4 * $urandom_range(9, 0) + (p % 4) + 1;
            pkt.delete();
            repeat (len) pkt.push_back(8'($urandom));
            send_packet(pkt, 3);
        end
        drain_results();
        end_test("5 back to back packets");

        // Captured result and count read with a stalled response
        read_check(REG_RESULT, 3, last_crc);
        read_check(REG_PKT_COUNT, 4, 32'(pkt_sent));
        end_test("6 result and packet count");

        $display("checks passed: %0d, checks failed: %0d", pass_cnt, fail_cnt);
        if (fail_cnt == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

//--- project.f
+incdir+.
crc_pkg.sv
crc_byte_stage.sv
crc_engine.sv
crc_axil_regs.sv
crc_top.sv
tb_crc_top.sv

//--- run_sim.sh
#!/bin/sh
# Build the CRC testbench with Verilator, run it and judge the log
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_crc_top -f project.f -o sim_crc
./obj_dir/sim_crc | tee sim.log
if grep -qx "TEST OK" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi
